// File: Makefile
VERILATOR ?= verilator
TOP       ?= mam_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
logic/mam_pkg.sv
logic/mam_request_decode.sv
logic/mam_write_engine.sv
logic/mam_response.sv
logic/mam_top.sv
verif/mam_checker.sv
verif/mam_tb.sv

// File: logic/mam_pkg.sv
// Memory access unit shared definitions: flit types, header fields and FSM states
`default_nettype none

package mam_pkg;

  ////////////////////////////////////////////////////////////
  // Debug flit
  ////////////////////////////////////////////////////////////

  localparam int FLIT_WIDTH = 16;

  typedef logic [FLIT_WIDTH-1:0] flit_t;
  typedef logic [12:0]           beats_t;  // Burst length in words

  ////////////////////////////////////////////////////////////
  // Command header layout
  ////////////////////////////////////////////////////////////

  localparam int HDR_WE_BIT    = 15;  // 1 for write
  localparam int HDR_BURST_BIT = 14;  // 1 for incremental burst
  localparam int HDR_SYNC_BIT  = 13;  // Acknowledge when write completes

  // Destination, source and flags come before any payload
  localparam int PKT_HDR_FLITS = 3;

  // Type EVENT, subtype 0, reserved bits zero
  localparam flit_t EVENT_FLAGS = {2'b10, 4'b0000, 10'h000};

  ////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    DEC_IDLE,
    DEC_SRC,
    DEC_FLAGS,
    DEC_CMD,
    DEC_ADDR,
    DEC_REQUEST,
    DEC_BUSY
  } decode_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_SKIP_HDR,
    WR_COLLECT,
    WR_WAIT_READY
  } write_state_e;

  typedef enum logic [2:0] {
    RSP_IDLE,
    RSP_HDR,
    RSP_READ_DATA,
    RSP_SYNC_WAIT,
    RSP_ACK
  } resp_state_e;

endpackage

`default_nettype wire

// File: logic/mam_request_decode.sv
// Request decoder: parses the debug request packet and issues one memory request
`default_nettype none

module mam_request_decode
  import mam_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 32
) (
  input  logic                    clk,
  input  logic                    rst,

  input  logic                    debug_in_valid,
  input  flit_t                   debug_in_data,
  input  logic                    debug_in_last,
  output logic                    decode_in_ready,

  output logic                    req_valid,
  input  logic                    req_ready,
  output logic                    req_we,
  output logic [ADDR_WIDTH-1:0]   req_addr,
  output logic                    req_burst,
  output beats_t                  req_beats,
  output logic                    req_sync,
  output logic [DATA_WIDTH/8-1:0] write_strb,

  output flit_t                   src_addr,
  output logic                    write_start,
  output logic                    new_packet,
  output logic                    read_start,
  input  logic                    op_done
);

  localparam int ADDR_FLITS = ADDR_WIDTH / FLIT_WIDTH;
  localparam int ACNT_W     = (ADDR_FLITS > 1) ? $clog2(ADDR_FLITS) : 1;

  decode_state_e     state;
  logic [ACNT_W-1:0] addr_cnt;
  logic              in_xfer;
  logic              last_addr;

  // Header and address phases take flits, the rest belongs to the engines
  assign decode_in_ready = (state != DEC_REQUEST) && (state != DEC_BUSY);
  assign in_xfer         = debug_in_valid && decode_in_ready;
  assign last_addr       = (addr_cnt == ACNT_W'(ADDR_FLITS - 1));
  assign req_valid       = (state == DEC_REQUEST);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= DEC_IDLE;
      addr_cnt    <= '0;
      write_start <= 1'b0;
      read_start  <= 1'b0;
    end else begin
      write_start <= 1'b0;
      read_start  <= 1'b0;
      case (state)
        DEC_IDLE:  if (in_xfer) state <= DEC_SRC;    // Destination flit, ourselves
        DEC_SRC:   if (in_xfer) state <= DEC_FLAGS;
        DEC_FLAGS: if (in_xfer) state <= DEC_CMD;    // Flags carry nothing we need
        DEC_CMD: begin
          if (in_xfer) begin
            state    <= DEC_ADDR;
            addr_cnt <= '0;
          end
        end
        DEC_ADDR: begin
          if (in_xfer) begin
            addr_cnt <= addr_cnt + 1'b1;
            if (last_addr) state <= DEC_REQUEST;
          end
        end
        DEC_REQUEST: begin
          if (req_ready) begin
            state       <= DEC_BUSY;
            write_start <= req_we;   // Exactly one engine takes over
            read_start  <= !req_we;
          end
        end
        DEC_BUSY: if (op_done) state <= DEC_IDLE;
        default:  state <= DEC_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Request fields, captured as their flits go by
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      case (state)
        DEC_SRC: src_addr <= debug_in_data;
        DEC_CMD: begin
          req_we     <= debug_in_data[HDR_WE_BIT];
          req_burst  <= debug_in_data[HDR_BURST_BIT];
          req_sync   <= debug_in_data[HDR_SYNC_BIT];
          write_strb <= debug_in_data[DATA_WIDTH/8-1:0];
          req_beats  <= debug_in_data[HDR_BURST_BIT] ? beats_t'(debug_in_data[7:0])
                                                     : beats_t'(1);
        end
        DEC_ADDR: begin
          // Most significant address flit arrives first
          req_addr[ADDR_WIDTH-1-addr_cnt*FLIT_WIDTH -: FLIT_WIDTH] <= debug_in_data;
          if (last_addr) new_packet <= debug_in_last;  // Data follows in a fresh packet
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/mam_response.sv
// Response builder: sends read data as event packets and the sync write acknowledge
`default_nettype none

module mam_response
  import mam_pkg::*;
#(
  parameter int DATA_WIDTH  = 32,
  parameter int MAX_PKT_LEN = 8
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  read_start,
  input  logic                  ack_start,
  input  flit_t                 src_addr,
  input  beats_t                req_beats,
  input  flit_t                 id,

  input  logic                  read_valid,
  input  logic [DATA_WIDTH-1:0] read_data,
  output logic                  read_ready,
  input  logic                  write_complete,

  output logic                  debug_out_valid,
  output flit_t                 debug_out_data,
  output logic                  debug_out_last,
  input  logic                  debug_out_ready,

  output logic                  op_done
);

  localparam int SLOTS  = DATA_WIDTH / FLIT_WIDTH;
  localparam int SLOT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;
  localparam int PKT_W  = $clog2(MAX_PKT_LEN + 1);

  resp_state_e       state;
  logic [1:0]        hdr_cnt;
  logic [SLOT_W-1:0] slot;
  logic [PKT_W-1:0]  pkt_cnt;     // Flits sent in the current packet
  beats_t            beats_left;
  flit_t             hdr_flit;
  logic              hdr_done;
  logic              last_slot;
  logic              last_beat;
  logic              pkt_full;
  logic              out_xfer;

  always_comb begin
    case (hdr_cnt)
      2'd0:    hdr_flit = src_addr;  // Back to the requester
      2'd1:    hdr_flit = id;
      default: hdr_flit = EVENT_FLAGS;
    endcase
  end

  assign hdr_done  = (hdr_cnt == 2'(PKT_HDR_FLITS - 1));
  assign last_slot = (slot == SLOT_W'(SLOTS - 1));
  assign last_beat = (beats_left == beats_t'(1));
  assign pkt_full  = (pkt_cnt == PKT_W'(MAX_PKT_LEN - 1));
  assign out_xfer  = debug_out_valid && debug_out_ready;

  ////////////////////////////////////////////////////////////
  // Output flit
  ////////////////////////////////////////////////////////////

  always_comb begin
    debug_out_valid = 1'b0;
    debug_out_data  = hdr_flit;
    debug_out_last  = 1'b0;
    case (state)
      RSP_HDR: debug_out_valid = 1'b1;
      RSP_ACK: begin
        debug_out_valid = 1'b1;
        debug_out_last  = hdr_done;  // Acknowledge is header only
      end
      RSP_READ_DATA: begin
        debug_out_valid = read_valid;
        debug_out_data  = read_data[DATA_WIDTH-1-slot*FLIT_WIDTH -: FLIT_WIDTH];
        debug_out_last  = pkt_full || (last_slot && last_beat);
      end
      default: ;
    endcase
  end

  // Beat consumed with its final flit
  assign read_ready = (state == RSP_READ_DATA) && out_xfer && last_slot;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= RSP_IDLE;
      hdr_cnt    <= '0;
      slot       <= '0;
      pkt_cnt    <= '0;
      beats_left <= '0;
      op_done    <= 1'b0;
    end else begin
      op_done <= 1'b0;
      case (state)
        RSP_IDLE: begin
          if (read_start) begin
            state      <= RSP_HDR;
            beats_left <= req_beats;
            slot       <= '0;
          end else if (ack_start) begin
            state <= RSP_SYNC_WAIT;
          end
        end
        RSP_HDR: begin
          if (out_xfer) begin
            hdr_cnt <= hdr_done ? 2'd0 : hdr_cnt + 2'd1;
            if (hdr_done) begin
              state   <= RSP_READ_DATA;
              pkt_cnt <= PKT_W'(PKT_HDR_FLITS);
            end
          end
        end
        RSP_READ_DATA: begin
          if (out_xfer) begin
            pkt_cnt <= pkt_cnt + 1'b1;
            if (last_slot) begin
              slot       <= '0;
              beats_left <= beats_left - 1'b1;
            end else begin
              slot <= slot + 1'b1;
            end
            if (last_slot && last_beat) begin
              state   <= RSP_IDLE;
              op_done <= 1'b1;
            end else if (pkt_full) begin
              state <= RSP_HDR;  // Packet limit reached, open another
            end
          end
        end
        RSP_SYNC_WAIT: if (write_complete) state <= RSP_ACK;
        RSP_ACK: begin
          if (out_xfer) begin
            hdr_cnt <= hdr_done ? 2'd0 : hdr_cnt + 2'd1;
            if (hdr_done) begin
              state   <= RSP_IDLE;
              op_done <= 1'b1;
            end
          end
        end
        default: state <= RSP_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/mam_top.sv
// Memory access unit top level: debug packet port to memory request, write and read ports
`default_nettype none

module mam_top
  import mam_pkg::*;
#(
  parameter int DATA_WIDTH  = 32,
  parameter int ADDR_WIDTH  = 32,
  parameter int MAX_PKT_LEN = 8
) (
  input  logic                    clk,
  input  logic                    rst,
  input  flit_t                   id,

  input  logic                    debug_in_valid,
  input  flit_t                   debug_in_data,
  input  logic                    debug_in_last,
  output logic                    debug_in_ready,

  output logic                    debug_out_valid,
  output flit_t                   debug_out_data,
  output logic                    debug_out_last,
  input  logic                    debug_out_ready,

  output logic                    req_valid,
  input  logic                    req_ready,
  output logic                    req_we,
  output logic [ADDR_WIDTH-1:0]   req_addr,
  output logic                    req_burst,
  output beats_t                  req_beats,
  output logic                    req_sync,

  output logic                    write_valid,
  output logic [DATA_WIDTH-1:0]   write_data,
  output logic [DATA_WIDTH/8-1:0] write_strb,
  input  logic                    write_ready,
  input  logic                    write_complete,

  input  logic                    read_valid,
  input  logic [DATA_WIDTH-1:0]   read_data,
  output logic                    read_ready
);

  logic  decode_in_ready;
  logic  write_in_ready;
  logic  write_start;
  logic  new_packet;
  logic  read_start;
  logic  ack_start;
  logic  wr_op_done;
  logic  rsp_op_done;
  logic  op_done;
  flit_t src_addr;

  // Decoder and write engine never take flits in the same state
  assign debug_in_ready = decode_in_ready | write_in_ready;
  assign op_done        = wr_op_done | rsp_op_done;

  mam_request_decode #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_decode (
    .clk, .rst,
    .debug_in_valid, .debug_in_data, .debug_in_last, .decode_in_ready,
    .req_valid, .req_ready, .req_we, .req_addr, .req_burst, .req_beats, .req_sync,
    .write_strb, .src_addr, .write_start, .new_packet, .read_start, .op_done
  );

  mam_write_engine #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_write (
    .clk, .rst,
    .debug_in_valid, .debug_in_data, .debug_in_last, .write_in_ready,
    .write_start, .new_packet, .req_beats, .req_sync,
    .write_valid, .write_data, .write_ready,
    .op_done   (wr_op_done),
    .ack_start
  );

  mam_response #(
    .DATA_WIDTH  (DATA_WIDTH),
    .MAX_PKT_LEN (MAX_PKT_LEN)
  ) u_resp (
    .clk, .rst,
    .read_start, .ack_start, .src_addr, .req_beats, .id,
    .read_valid, .read_data, .read_ready, .write_complete,
    .debug_out_valid, .debug_out_data, .debug_out_last, .debug_out_ready,
    .op_done   (rsp_op_done)
  );

endmodule

`default_nettype wire

// File: logic/mam_write_engine.sv
// Write engine: packs payload flits into memory words across packets and drives the write port
`default_nettype none

module mam_write_engine
  import mam_pkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  debug_in_valid,
  input  flit_t                 debug_in_data,
  input  logic                  debug_in_last,
  output logic                  write_in_ready,

  input  logic                  write_start,
  input  logic                  new_packet,
  input  beats_t                req_beats,
  input  logic                  req_sync,

  output logic                  write_valid,
  output logic [DATA_WIDTH-1:0] write_data,
  input  logic                  write_ready,

  output logic                  op_done,
  output logic                  ack_start
);

  localparam int SLOTS  = DATA_WIDTH / FLIT_WIDTH;
  localparam int SLOT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;

  write_state_e          state;
  logic [1:0]            hdr_cnt;
  logic [SLOT_W-1:0]     word_cnt;    // Flit slot, carries across packets
  beats_t                beats_left;
  logic                  in_packet;   // Packet still open while stalled
  logic [DATA_WIDTH-1:0] word_reg;
  logic [DATA_WIDTH-1:0] word_merged;
  logic                  last_slot;
  logic                  last_beat;
  logic                  hdr_done;
  logic                  beat_xfer;
  logic                  pkt_open;

  assign write_in_ready = (state == WR_SKIP_HDR) || (state == WR_COLLECT);
  assign last_slot      = (word_cnt == SLOT_W'(SLOTS - 1));
  assign last_beat      = (beats_left == beats_t'(1));
  assign hdr_done       = (hdr_cnt == 2'(PKT_HDR_FLITS - 1));

  // Current flit dropped into its slot
  always_comb begin
    word_merged = word_reg;
    word_merged[DATA_WIDTH-1-word_cnt*FLIT_WIDTH -: FLIT_WIDTH] = debug_in_data;
  end

  assign write_valid = (state == WR_WAIT_READY) ||
                       ((state == WR_COLLECT) && debug_in_valid && last_slot);
  assign write_data  = (state == WR_WAIT_READY) ? word_reg : word_merged;
  assign beat_xfer   = write_valid && write_ready;
  assign pkt_open    = (state == WR_WAIT_READY) ? in_packet : !debug_in_last;

  always_ff @(posedge clk) begin
    if ((state == WR_COLLECT) && debug_in_valid) word_reg <= word_merged;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= WR_IDLE;
      hdr_cnt    <= '0;
      word_cnt   <= '0;
      beats_left <= '0;
      in_packet  <= 1'b0;
      op_done    <= 1'b0;
      ack_start  <= 1'b0;
    end else begin
      op_done   <= 1'b0;
      ack_start <= 1'b0;
      case (state)
        WR_IDLE: begin
          if (write_start) begin
            beats_left <= req_beats;
            word_cnt   <= '0;
            state      <= new_packet ? WR_SKIP_HDR : WR_COLLECT;
          end
        end
        WR_SKIP_HDR: begin
          if (debug_in_valid) begin
            hdr_cnt <= hdr_done ? 2'd0 : hdr_cnt + 2'd1;
            if (hdr_done) state <= WR_COLLECT;
          end
        end
        WR_COLLECT: begin
          if (debug_in_valid) begin
            if (last_slot) begin
              word_cnt <= '0;
              if (!write_ready) begin
                state     <= WR_WAIT_READY;
                in_packet <= !debug_in_last;
              end
            end else begin
              word_cnt <= word_cnt + 1'b1;
              if (debug_in_last) state <= WR_SKIP_HDR;  // Word continues next packet
            end
          end
        end
        default: ;  // WR_WAIT_READY leaves through the beat below
      endcase

      // A finished word goes to memory
      if (beat_xfer) begin
        beats_left <= beats_left - 1'b1;
        if (last_beat) begin
          state     <= WR_IDLE;
          op_done   <= !req_sync;
          ack_start <= req_sync;
        end else begin
          state <= pkt_open ? WR_COLLECT : WR_SKIP_HDR;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/mam_checker.sv
// Memory access unit checker: compares DUT port activity with queued expected transfers
`default_nettype none

module mam_checker
  import mam_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        debug_in_ready,
  input  logic        debug_out_valid,
  input  flit_t       debug_out_data,
  input  logic        debug_out_last,
  input  logic        debug_out_ready,
  input  logic        req_valid,
  input  logic        req_ready,
  input  logic        req_we,
  input  logic [31:0] req_addr,
  input  logic        req_burst,
  input  beats_t      req_beats,
  input  logic        req_sync,
  input  logic        write_valid,
  input  logic [31:0] write_data,
  input  logic [3:0]  write_strb,
  input  logic        write_ready,
  input  logic        write_complete,
  input  logic        read_ready,
  output int          errors
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [47:0] exp_req[$];  // we, burst, beats, sync, addr
  logic [35:0] exp_wr[$];   // strb, data
  logic [16:0] exp_out[$];  // last, flit
  int          exp_rd_beats;
  int          rd_beats;
  int          tests_run;
  int          tests_failed;
  int          errors_at_start;
  logic        cur_we;
  logic        wc_seen;      // write_complete high since the last write beat

  initial begin
    errors          = 0;
    exp_rd_beats    = 0;
    rd_beats        = 0;
    tests_run       = 0;
    tests_failed    = 0;
    errors_at_start = 0;
    cur_we          = 1'b0;
    wc_seen         = 1'b0;
  end

  task automatic expect_req(input logic we, input logic burst, input beats_t beats,
                            input logic sync, input logic [31:0] addr);
    exp_req.push_back({we, burst, beats, sync, addr});
  endtask

  task automatic expect_write(input logic [31:0] data, input logic [3:0] strb);
    exp_wr.push_back({strb, data});
  endtask

  task automatic expect_flit(input logic last, input flit_t data);
    exp_out.push_back({last, data});
  endtask

  task automatic expect_read_beats(input int n);
    exp_rd_beats = n;
  endtask

  task automatic check_reset_state();
    if (req_valid || write_valid || read_ready || debug_out_valid || !debug_in_ready) begin
      $display("ERR %0t: outputs not idle after reset", $time);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Port monitor, sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    logic [47:0] req_got;
    logic [35:0] wr_got;
    logic [16:0] out_got;
    logic [47:0] req_exp;
    logic [35:0] wr_exp;
    logic [16:0] out_exp;
    if (!rst) begin
      req_got = {req_we, req_burst, req_beats, req_sync, req_addr};
      wr_got  = {write_strb, write_data};
      out_got = {debug_out_last, debug_out_data};
      if (req_valid && req_ready) begin
        cur_we  = req_we;
        wc_seen = 1'b0;
        if (exp_req.size() == 0) begin
          $display("Unexpected memory request at time %0t", $time);
          errors++;
        end else begin
          req_exp = exp_req.pop_front();
          if (req_got !== req_exp) begin
            $display("ERR %0t: request got %h exp %h", $time, req_got, req_exp);
            errors++;
          end
        end
      end
      if (write_valid && write_ready) begin
        wc_seen = 1'b0;
        if (exp_wr.size() == 0) begin
          $display("Unexpected write beat at time %0t", $time);
          errors++;
        end else begin
          wr_exp = exp_wr.pop_front();
          if (wr_got !== wr_exp) begin
            $display("ERR %0t: write beat got %h exp %h", $time, wr_got, wr_exp);
            errors++;
          end
        end
      end
      if (write_complete) wc_seen = 1'b1;
      if (debug_out_valid && debug_out_ready) begin
        if (cur_we && !wc_seen) begin
          $display("ERR %0t: acknowledge flit before write_complete", $time);
          errors++;
        end
        if (exp_out.size() == 0) begin
          $display("Unexpected output flit %h at time %0t", debug_out_data, $time);
          errors++;
        end else begin
          out_exp = exp_out.pop_front();
          if (out_got !== out_exp) begin
            $display("ERR %0t: output flit got %h exp %h", $time, out_got, out_exp);
            errors++;
          end
        end
      end
      if (read_ready) rd_beats++;
    end
  end

  task automatic end_test(input int num, input string name);
    if (exp_req.size() != 0 || exp_wr.size() != 0 || exp_out.size() != 0) begin
      $display("Test %0d ended with expected transfers still missing", num);
      errors++;
    end
    if (rd_beats != exp_rd_beats) begin
      $display("ERR %0t: read_ready pulses %0d exp %0d", $time, rd_beats, exp_rd_beats);
      errors++;
    end
    exp_req.delete();
    exp_wr.delete();
    exp_out.delete();
    rd_beats     = 0;
    exp_rd_beats = 0;
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", num, name, errors - errors_at_start);
    end else begin
      $display("test %0d %s: ok", num, name);
    end
    errors_at_start = errors;
  endtask

  task automatic report();
    $display("tests %0d, passing %0d, failing %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
  endtask

endmodule

`default_nettype wire

// File: verif/mam_tb.sv
// Memory access unit testbench: random debug packets, memory responder and reference model
`default_nettype none

module mam_tb
  import mam_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    DATA_WIDTH      = 32;
  localparam int    ADDR_WIDTH      = 32;
  localparam int    MAX_PKT_LEN     = 8;
  localparam int    NUM_TESTS       = 40;
  localparam int    CYCLES_PER_TEST = 2000;
  localparam flit_t UNIT_ID         = 16'h0012;

  logic                    clk;
  logic                    rst;
  logic                    debug_in_valid;
  flit_t                   debug_in_data;
  logic                    debug_in_last;
  logic                    debug_in_ready;
  logic                    debug_out_valid;
  flit_t                   debug_out_data;
  logic                    debug_out_last;
  logic                    debug_out_ready;
  logic                    req_valid;
  logic                    req_ready;
  logic                    req_we;
  logic [ADDR_WIDTH-1:0]   req_addr;
  logic                    req_burst;
  beats_t                  req_beats;
  logic                    req_sync;
  logic                    write_valid;
  logic [DATA_WIDTH-1:0]   write_data;
  logic [DATA_WIDTH/8-1:0] write_strb;
  logic                    write_ready;
  logic                    write_complete;
  logic                    read_valid;
  logic [DATA_WIDTH-1:0]   read_data;
  logic                    read_ready;
  int                      errors;

  logic [31:0] rng_state;
  logic [31:0] model [logic [31:0]];  // Reference contents, updated as tests are generated
  logic [31:0] mem   [logic [31:0]];  // Responder contents, updated by real write beats

  mam_top u_mam_top (
    .id (UNIT_ID),
    .*
  );

  mam_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Unwritten words read back as a pattern of the full address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Debug input driver
  ////////////////////////////////////////////////////////////

  task automatic send_flit(input flit_t data, input logic last);
    logic [31:0] r;
    r = next_rand();
    if (r[1:0] == 2'd0) begin  // Occasional idle gap
      @(posedge clk);
      #1;
    end
    debug_in_valid = 1'b1;
    debug_in_data  = data;
    debug_in_last  = last;
    do @(negedge clk); while (!debug_in_ready);
    @(posedge clk);
    #1;
    debug_in_valid = 1'b0;
    debug_in_last  = 1'b0;
  endtask

  // Unit is free again once the decoder takes flits
  task automatic wait_done();
    do @(negedge clk); while (!debug_in_ready);
    @(posedge clk);
    #1;
  endtask

  task automatic run_test(input int num);
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] a;
    logic [3:0]  strb;
    logic        we;
    logic        burst;
    logic        sync;
    logic        split;
    logic        cont;
    logic        last;
    int          kind;
    int          beats;
    int          n;
    flit_t       src;
    flit_t       cmd;
    flit_t       f;
    flit_t       data_flits[$];
    string       name;
    r = next_rand();
    kind = r % 4;
    r = next_rand();
    src = r[15:0];
    r = next_rand();
    addr  = 32'h0001_0000 | (r & 32'h0000_003c);
    strb  = r[11:8];
    split = r[12];
    r = next_rand();
    case (kind)
      0: begin
        name  = "single write";
        burst = 1'b0;
        beats = 1;
      end
      1: begin
        name  = "burst write";
        burst = 1'b1;
        beats = 2 + r % 5;
      end
      2: begin
        name  = "sync write";
        burst = r[8];
        beats = burst ? 1 + r % 4 : 1;
      end
      default: begin
        name  = "read";
        burst = r[8];
        beats = burst ? 1 + r % 6 : 1;
      end
    endcase
    we   = (kind != 3);
    sync = (kind == 2);
    cmd  = burst ? {we, 1'b1, sync, 5'b0, 8'(beats)} : {we, 1'b0, sync, 9'b0, strb};
    u_checker.expect_req(we, burst, beats_t'(beats), sync, addr);

    if (we) begin
      for (int b = 0; b < beats; b++) begin
        word = next_rand();
        a    = addr + 32'(4 * b);
        u_checker.expect_write(word, cmd[3:0]);
        model[a] = merge_bytes(model.exists(a) ? model[a] : fill_word(a), word,
                               burst ? 4'hf : cmd[3:0]);
        data_flits.push_back(word[31:16]);  // Big-end first
        data_flits.push_back(word[15:0]);
      end
      if (sync) begin
        u_checker.expect_flit(1'b0, src);
        u_checker.expect_flit(1'b0, UNIT_ID);
        u_checker.expect_flit(1'b1, EVENT_FLAGS);
      end
    end else begin
      u_checker.expect_read_beats(beats);
      n = 0;
      for (int b = 0; b < beats; b++) begin
        a    = addr + 32'(4 * b);
        word = model.exists(a) ? model[a] : fill_word(a);
        for (int s = 0; s < 2; s++) begin
          if (n == 0) begin
            u_checker.expect_flit(1'b0, src);
            u_checker.expect_flit(1'b0, UNIT_ID);
            u_checker.expect_flit(1'b0, EVENT_FLAGS);
            n = PKT_HDR_FLITS;
          end
          n++;
          last = ((b == beats - 1) && (s == 1)) || (n == MAX_PKT_LEN);
          u_checker.expect_flit(last, word[31 - 16 * s -: 16]);
          if (last) n = 0;
        end
      end
    end

    // Request packet
    send_flit(UNIT_ID, 1'b0);
    send_flit(src, 1'b0);
    send_flit(r[31:16], 1'b0);  // Flags, ignored by the unit
    send_flit(cmd, 1'b0);
    send_flit(addr[31:16], 1'b0);
    send_flit(addr[15:0], !we || split);

    // Payload, spread over packets of random length
    cont = we && !split;
    while (data_flits.size() > 0) begin
      if (!cont) begin
        send_flit(UNIT_ID, 1'b0);
        send_flit(src, 1'b0);
        send_flit(16'h0000, 1'b0);
      end
      cont = 1'b0;
      r = next_rand();
      n = 1 + r % 5;
      for (int i = 0; i < n && data_flits.size() > 0; i++) begin
        f = data_flits.pop_front();
        send_flit(f, (i == n - 1) || (data_flits.size() == 0));
      end
    end

    wait_done();
    u_checker.end_test(num, name);
  endtask

  ////////////////////////////////////////////////////////////
  // Memory responder
  ////////////////////////////////////////////////////////////

  initial begin : responder
    logic        req_fire;
    logic        wr_fire;
    logic        rd_fire;
    logic        cur_we;
    logic        cur_burst;
    logic        cur_sync;
    logic [31:0] cur_addr;
    logic [31:0] wr_word;
    logic [3:0]  wr_strb;
    logic [31:0] r;
    logic [31:0] a;
    int          cur_beats;
    int          beat_idx;
    int          rd_delay;
    int          wc_delay;
    cur_we    = 1'b0;
    cur_burst = 1'b0;
    cur_sync  = 1'b0;
    cur_addr  = '0;
    cur_beats = 0;
    beat_idx  = 0;
    rd_delay  = 0;
    wc_delay  = -1;
    forever begin
      @(negedge clk);
      req_fire = req_valid && req_ready;
      wr_fire  = write_valid && write_ready;
      rd_fire  = read_ready;
      wr_word  = write_data;
      wr_strb  = write_strb;
      if (req_fire) begin
        cur_we    = req_we;
        cur_burst = req_burst;
        cur_sync  = req_sync;
        cur_addr  = req_addr;
        cur_beats = int'(req_beats);
      end
      @(posedge clk);
      #1;
      r = next_rand();
      if (req_fire) begin
        beat_idx       = 0;
        rd_delay       = r % 6;
        wc_delay       = -1;
        write_complete = 1'b0;
      end
      if (wr_fire) begin
        a = cur_addr + 32'(4 * beat_idx);
        mem[a] = merge_bytes(mem.exists(a) ? mem[a] : fill_word(a), wr_word,
                             cur_burst ? 4'hf : wr_strb);
        beat_idx++;
        if (beat_idx == cur_beats && cur_sync) wc_delay = 1 + r % 8;
      end
      if (wc_delay == 0) write_complete = 1'b1;
      if (wc_delay >= 0) wc_delay--;
      if (rd_fire) begin
        read_valid = 1'b0;
        beat_idx++;
        rd_delay = r % 4;
      end
      if (!cur_we && beat_idx < cur_beats && !read_valid) begin
        if (rd_delay == 0) begin
          a          = cur_addr + 32'(4 * beat_idx);
          read_valid = 1'b1;
          read_data  = mem.exists(a) ? mem[a] : fill_word(a);
        end else begin
          rd_delay--;
        end
      end
      req_ready       = r[8];
      write_ready     = r[10:9] != 2'b00;
      debug_out_ready = r[13:11] > 3'd1;  // Mostly ready, some back-pressure
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    rng_state       = 32'd80;
    rst             = 1'b1;
    debug_in_valid  = 1'b0;
    debug_in_data   = '0;
    debug_in_last   = 1'b0;
    debug_out_ready = 1'b0;
    req_ready       = 1'b0;
    write_ready     = 1'b0;
    write_complete  = 1'b0;
    read_valid      = 1'b0;
    read_data       = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    u_checker.check_reset_state();
    @(posedge clk);
    #1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    repeat (5) @(posedge clk);
    u_checker.report();
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST + 100) @(posedge clk);
    $display("Watchdog expired: the tests did not finish in the allowed time");
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
